/* build.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/async_receiver.sv
hdl/async_transmitter.sv
hdl/uart.sv
tb/tb_uart.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the serial terminal testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_uart -f build.f

# the log decides pass or fail, so a failing run must not stop the script here
./obj_dir/Vtb_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
else
    exit 1
fi

/* tb/tb_uart.sv */
// ~~~~~~~~~~~~~~~~~~~~
// serial terminal testbench
// directed tests of the register block with a serial line model
// on both the receive and the transmit side
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "uart_config.svh"

module tb_uart;

    localparam int BIT_CYCLES = `UART_CLK_FREQ / `UART_BAUD;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int POLL_LIMIT = 2 * FRAME_CYCLES;

    logic                 clk;
    logic                 reset;
    logic                 enable;
    uart_pkg::reg_addr_t  address;
    logic                 w_en;
    uart_pkg::data_byte_t din;
    uart_pkg::data_byte_t dout;
    logic                 uart_rx;
    logic                 uart_tx;
    logic                 uart_cts;
    integer               seed;

    uart UUT (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .address(address),
        .w_en(w_en),
        .din(din),
        .dout(dout),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .uart_cts(uart_cts)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // all driving and sampling happens just after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_byte(input string name, input uart_pkg::data_byte_t expected,
                              input uart_pkg::data_byte_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic bus_write(input uart_pkg::reg_addr_t addr, input uart_pkg::data_byte_t value);
        address = addr;
        din = value;
        w_en = 1'b1;
        enable = 1'b1;
        step();
        enable = 1'b0;
        w_en = 1'b0;
    endtask

    // dout follows the address one cycle later
    task automatic bus_read(input uart_pkg::reg_addr_t addr, output uart_pkg::data_byte_t value);
        address = addr;
        w_en = 1'b0;
        enable = 1'b1;
        step();
        enable = 1'b0;
        value = dout;
    endtask

    // 8N1 frame, lsb first, followed by one bit time of idle line
    task automatic send_frame(input uart_pkg::data_byte_t value, input logic stop_bit);
        int k;
        uart_rx = 1'b0;
        repeat (BIT_CYCLES) step();
        for (k = 0; k < 8; k++)
        begin
            uart_rx = value[k];
            repeat (BIT_CYCLES) step();
        end
        uart_rx = stop_bit;
        repeat (BIT_CYCLES) step();
        uart_rx = 1'b1;
        repeat (BIT_CYCLES) step();
    endtask

    task automatic capture_frame(output uart_pkg::data_byte_t value, output logic stop_bit);
        int n;
        int k;
        n = 0;
        while (uart_tx !== 1'b0)
        begin
            if (n == POLL_LIMIT)
                report_timeout("no start bit seen on uart_tx");
            step();
            n++;
        end
        // move to the middle of the start bit
        repeat (BIT_CYCLES / 2) step();
        check_bit("uart_tx start bit", 1'b0, uart_tx);
        for (k = 0; k < 8; k++)
        begin
            repeat (BIT_CYCLES) step();
            value[k] = uart_tx;
        end
        repeat (BIT_CYCLES) step();
        stop_bit = uart_tx;
    endtask

    task automatic wait_rx_status(output uart_pkg::data_byte_t value);
        int n;
        n = 0;
        bus_read(uart_pkg::RX_CTRL, value);
        while (value[7] !== 1'b1)
        begin
            if (n == POLL_LIMIT)
                report_timeout("receive status never set");
            bus_read(uart_pkg::RX_CTRL, value);
            n++;
        end
    endtask

    task automatic wait_tx_idle(output uart_pkg::data_byte_t value);
        int n;
        n = 0;
        bus_read(uart_pkg::TX_DATA, value);
        while (value[7] !== 1'b0)
        begin
            if (n == POLL_LIMIT)
                report_timeout("transmitter stayed busy");
            bus_read(uart_pkg::TX_DATA, value);
            n++;
        end
    endtask

    task automatic wait_cts_low();
        int n;
        n = 0;
        while (uart_cts !== 1'b0)
        begin
            if (n == 2 * POLL_LIMIT)
                report_timeout("uart_cts never dropped");
            step();
            n++;
        end
    endtask

    task automatic test_reset_state();
        uart_pkg::data_byte_t v;
        check_bit("uart_tx", 1'b1, uart_tx);
        check_bit("uart_cts", 1'b0, uart_cts);
        bus_read(uart_pkg::RX_DATA, v);
        check_byte("dout rx_data", 8'h00, v);
        bus_read(uart_pkg::RX_CTRL, v);
        check_byte("dout rx_ctrl", 8'h00, v);
        bus_read(uart_pkg::TX_DATA, v);
        check_byte("dout tx_data", 8'h00, v);
        bus_read(uart_pkg::reg_addr_t'(2'd3), v);
        check_byte("dout unused", 8'h00, v);
    endtask

    task automatic test_initial_swallow();
        uart_pkg::data_byte_t v;
        bus_write(uart_pkg::TX_DATA, 8'h7f);
        repeat (2 * FRAME_CYCLES)
        begin
            step();
            check_bit("uart_tx", 1'b1, uart_tx);
        end
        bus_read(uart_pkg::TX_DATA, v);
        check_byte("dout tx_data", 8'h00, v);
    endtask

    task automatic test_transmit();
        uart_pkg::data_byte_t b;
        uart_pkg::data_byte_t v;
        uart_pkg::data_byte_t got;
        logic stop;
        int i;
        for (i = 0; i < 4; i++)
        begin
            b = 8'($random(seed));
            // make sure bit 7 clearing is exercised at least once
            if (i == 0)
                b[7] = 1'b1;
            bus_write(uart_pkg::TX_DATA, b);
            step();
            bus_read(uart_pkg::TX_DATA, v);
            check_byte("dout tx busy", 8'h80, v);
            capture_frame(got, stop);
            check_byte("uart_tx data", {1'b0, b[6:0]}, got);
            check_bit("uart_tx stop bit", 1'b1, stop);
            wait_tx_idle(v);
            check_byte("dout tx idle", 8'h00, v);
        end
    endtask

    task automatic test_receive();
        uart_pkg::data_byte_t b;
        uart_pkg::data_byte_t v;
        b = 8'($random(seed));
        send_frame(b, 1'b1);
        wait_rx_status(v);
        check_byte("dout rx_ctrl", 8'h80, v);
        check_bit("uart_cts", 1'b1, uart_cts);
        bus_read(uart_pkg::RX_DATA, v);
        check_byte("dout rx_data", {1'b1, b[6:0]}, v);
        // status clears the cycle after the acknowledge
        step();
        bus_read(uart_pkg::RX_CTRL, v);
        check_byte("dout rx_ctrl", 8'h00, v);
        check_bit("uart_cts", 1'b1, uart_cts);
        wait_cts_low();
    endtask

    task automatic test_overrun();
        uart_pkg::data_byte_t b1;
        uart_pkg::data_byte_t b2;
        uart_pkg::data_byte_t v;
        b1 = 8'($random(seed));
        b2 = b1 ^ 8'h55;
        send_frame(b1, 1'b1);
        send_frame(b2, 1'b1);
        wait_rx_status(v);
        bus_read(uart_pkg::RX_DATA, v);
        check_byte("dout rx_data", {1'b1, b1[6:0]}, v);
        repeat (2 * BIT_CYCLES) step();
        bus_read(uart_pkg::RX_CTRL, v);
        check_byte("dout rx_ctrl", 8'h00, v);
    endtask

    task automatic test_frame_error();
        uart_pkg::data_byte_t v;
        send_frame(8'($random(seed)), 1'b0);
        repeat (4 * BIT_CYCLES) step();
        bus_read(uart_pkg::RX_CTRL, v);
        check_byte("dout rx_ctrl", 8'h00, v);
    endtask

    initial
    begin
        seed = 23;
        reset = 1'b1;
        enable = 1'b0;
        address = uart_pkg::RX_DATA;
        w_en = 1'b0;
        din = 8'h00;
        uart_rx = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        step();

        test_reset_state();
        test_initial_swallow();
        test_transmit();
        test_receive();
        test_overrun();
        test_frame_error();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdl/uart.sv */
// ~~~~~~~~~~~~~~~~~~~~
// serial terminal register block
// PIA style receive data, receive control and transmit registers in front
// of the asynchronous receiver and transmitter
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module uart (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  uart_pkg::reg_addr_t  address,
    input  logic                 w_en,
    input  uart_pkg::data_byte_t din,
    output uart_pkg::data_byte_t dout,
    input  logic                 uart_rx,
    output logic                 uart_tx,
    output logic                 uart_cts
);

    logic                 tx_start;
    logic                 tx_init;
    logic                 tx_busy;
    logic                 tx_write;
    logic                 tx_accept;
    uart_pkg::data_byte_t tx_byte;

    logic                 rx_ready;
    logic                 rx_idle;
    logic                 rx_status;
    logic                 rx_ack;
    logic                 rx_read;
    uart_pkg::data_byte_t rx_data;
    uart_pkg::char_t      rx_char;

    async_transmitter tx_inst (
        .clk(clk),
        .reset(reset),
        .start(tx_start),
        .data(tx_byte),
        .txd(uart_tx),
        .busy(tx_busy)
    );

    async_receiver rx_inst (
        .clk(clk),
        .reset(reset),
        .rxd(uart_rx),
        .data_ready(rx_ready),
        .data(rx_data),
        .idle(rx_idle)
    );

    assign tx_write = enable && w_en && (address == uart_pkg::TX_DATA);
    assign rx_read = enable && !w_en && (address == uart_pkg::RX_DATA);
    // the monitor's port setup write arrives before tx_init is set
    assign tx_accept = tx_write && !tx_busy && tx_init;

    // terminal is 7 bit, so bit 7 never goes out on the line
    always_ff @(posedge clk)
    begin
        if (tx_accept)
            tx_byte <= {1'b0, din[6:0]};
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tx_init <= 1'b0;
            tx_start <= 1'b0;
            rx_ack <= 1'b0;
            rx_status <= 1'b0;
            rx_char <= '0;
        end
        else
        begin
            tx_start <= tx_accept;
            if (tx_write && !tx_init)
                tx_init <= 1'b1;

            rx_ack <= rx_read && !rx_ack;
            // new byte only lands when the CPU has taken the last one
            if (rx_ready && !rx_status)
            begin
                rx_status <= 1'b1;
                rx_char <= rx_data[6:0];
            end
            else if (rx_ack)
                rx_status <= 1'b0;
        end
    end

    // read port, one cycle behind the address
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            dout <= '0;
        else
        begin
            case (address)
                uart_pkg::RX_DATA: dout <= {rx_status, rx_char};
                uart_pkg::RX_CTRL: dout <= {rx_status, 7'd0};
                uart_pkg::TX_DATA: dout <= {tx_busy, 7'd0};
                default:           dout <= '0;
            endcase
        end
    end

    // hold off the terminal while a frame arrives or a byte waits
    assign uart_cts = !rx_idle || rx_status;

endmodule

/* hdl/async_transmitter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// asynchronous transmitter
// sends one 8N1 frame per start pulse and holds busy until the stop bit ends
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module async_transmitter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  uart_pkg::data_byte_t data,
    output logic                 txd,
    output logic                 busy
);

    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_START = 4'd1;
    localparam logic [3:0] ST_BIT7  = 4'd9;
    localparam logic [3:0] ST_STOP  = 4'd10;

    logic                 bit_tick;
    logic [3:0]           state;
    uart_pkg::data_byte_t shifter;

    // bit timing restarts with every frame
    baud_tick_gen #(
        .OVERSAMPLING(1)
    ) bit_tick_gen (
        .clk(clk),
        .reset(reset),
        .enable(busy || start),
        .tick(bit_tick)
    );

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ST_IDLE;
        else if (state == ST_IDLE)
        begin
            if (start)
                state <= ST_START;
        end
        else if (bit_tick)
        begin
            if (state == ST_STOP)
                state <= ST_IDLE;
            else
                state <= state + 4'd1;
        end
    end

    // start pulses during a frame are ignored
    always_ff @(posedge clk)
    begin
        if (start && !busy)
            shifter <= data;
        else if (bit_tick && state > ST_START && state <= ST_BIT7)
            shifter <= {1'b0, shifter[7:1]};
    end

    // registered line output
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            txd <= 1'b1;
        else
        begin
            case (state)
                ST_IDLE:  txd <= 1'b1;
                ST_START: txd <= 1'b0;
                ST_STOP:  txd <= 1'b1;
                default:  txd <= shifter[0];
            endcase
        end
    end

endmodule

/* hdl/async_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// asynchronous receiver
// synchronizes and filters the line, finds start bits and shifts in
// 8N1 frames, flags a valid stop bit and reports an idle line
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "uart_config.svh"

module async_receiver (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rxd,
    output logic                 data_ready,
    output uart_pkg::data_byte_t data,
    output logic                 idle
);

    localparam int OS = `UART_OVERSAMPLING;
    localparam int OS_WIDTH = $clog2(OS);
    // sample point inside each bit, counted in sample ticks
    localparam logic [OS_WIDTH-1:0] OS_MID = OS_WIDTH'(OS / 2 - 1);

    // ten bit times of high line count as idle
    localparam int GAP_TICKS = 10 * OS;
    localparam int GAP_WIDTH = $clog2(GAP_TICKS + 1);
    localparam logic [GAP_WIDTH-1:0] GAP_LIMIT = GAP_WIDTH'(GAP_TICKS);

    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_START = 4'd1;
    localparam logic [3:0] ST_BIT0  = 4'd2;
    localparam logic [3:0] ST_BIT7  = 4'd9;
    localparam logic [3:0] ST_STOP  = 4'd10;

    logic                sample_tick;
    logic [1:0]          rxd_sync;
    logic [1:0]          samples;
    logic                rx_bit;
    logic [3:0]          state;
    logic [OS_WIDTH-1:0] os_cnt;
    logic                sample_now;
    logic [GAP_WIDTH-1:0] gap_cnt;

    baud_tick_gen #(
        .OVERSAMPLING(OS)
    ) sample_tick_gen (
        .clk(clk),
        .reset(reset),
        .enable(1'b1),
        .tick(sample_tick)
    );

    // two flop synchronizer, then majority of the last three samples
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rxd_sync <= 2'b11;
            samples <= 2'b11;
            rx_bit <= 1'b1;
        end
        else
        begin
            rxd_sync <= {rxd_sync[0], rxd};
            if (sample_tick)
            begin
                samples <= {samples[0], rxd_sync[1]};
                rx_bit <= (samples[1] & samples[0]) | (samples[1] & rxd_sync[1]) |
                          (samples[0] & rxd_sync[1]);
            end
        end
    end

    assign sample_now = sample_tick && (os_cnt == OS_MID);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            os_cnt <= '0;
            data_ready <= 1'b0;
        end
        else
        begin
            data_ready <= 1'b0;
            // phase restarts at each detected start edge
            if (state == ST_IDLE)
                os_cnt <= '0;
            else if (sample_tick)
                os_cnt <= os_cnt + 1'b1;

            case (state)
                ST_IDLE:
                begin
                    if (sample_tick && !rx_bit)
                        state <= ST_START;
                end
                ST_START:
                begin
                    // a start bit that is gone by mid-bit was a glitch
                    if (sample_now)
                        state <= rx_bit ? ST_IDLE : ST_BIT0;
                end
                ST_STOP:
                begin
                    if (sample_now)
                    begin
                        state <= ST_IDLE;
                        data_ready <= rx_bit;
                    end
                end
                default:
                begin
                    if (sample_now)
                        state <= state + 4'd1;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk)
    begin
        if (sample_now && state >= ST_BIT0 && state <= ST_BIT7)
            data <= {rx_bit, data[7:1]};
    end

    // line starts out idle after reset
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            gap_cnt <= GAP_LIMIT;
        else if (state != ST_IDLE)
            gap_cnt <= '0;
        else if (sample_tick && rx_bit && gap_cnt != GAP_LIMIT)
            gap_cnt <= gap_cnt + 1'b1;
    end

    assign idle = (gap_cnt == GAP_LIMIT);

endmodule

/* hdl/baud_tick_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// baud tick generator
// phase accumulator giving one-cycle ticks at baud rate times OVERSAMPLING
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "uart_config.svh"

module baud_tick_gen #(
    parameter int OVERSAMPLING = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic tick
);

    // eight bits of fraction beyond the clock to baud ratio
    localparam int ACC_WIDTH = $clog2(`UART_CLK_FREQ / `UART_BAUD) + 8;
    localparam longint RATE = longint'(`UART_BAUD) * OVERSAMPLING;
    localparam longint INC_FULL = ((RATE << ACC_WIDTH) + (`UART_CLK_FREQ / 2)) / `UART_CLK_FREQ;
    localparam logic [ACC_WIDTH:0] INC = (ACC_WIDTH + 1)'(INC_FULL);

    logic [ACC_WIDTH:0] acc;

    // top bit is the carry out of the accumulator
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            acc <= '0;
        else if (enable)
            acc <= {1'b0, acc[ACC_WIDTH-1:0]} + INC;
        else
            acc <= '0;
    end

    assign tick = acc[ACC_WIDTH];

endmodule

/* hdl/uart_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// serial terminal types
// register map and data types used on the bus and the serial path
// ~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

    // register map as seen from the CPU
    // value 3 is unused and reads as zero
    typedef enum logic [1:0] {
        RX_DATA = 2'd0,
        RX_CTRL = 2'd1,
        TX_DATA = 2'd2
    } reg_addr_t;

    // one byte on the bus and on the serial line
    typedef logic [7:0] data_byte_t;

    // terminal character without the top bit
    typedef logic [6:0] char_t;

endpackage

/* hdl/uart_config.svh */
// ~~~~~~~~~~~~~~~~~~~~
// serial terminal configuration
// clock, bit rate and receiver oversampling shared by the serial stages
// ~~~~~~~~~~~~~~~~~~~~

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clock in Hz
`define UART_CLK_FREQ 25000000

// serial bit rate
// 16 clock cycles per bit keeps simulation short
`define UART_BAUD 1562500

// receiver samples per bit period
`define UART_OVERSAMPLING 8

`endif
